//--- rtl/cpu_pkg.sv
package cpu_pkg;

	localparam int pc_width        = 26;
	localparam int data_width      = 32;
	localparam int program_size    = 51;
	localparam int dmem_words      = 64;
	localparam int dmem_addr_width = $clog2(dmem_words);
	localparam int reg_addr_width  = 5;
	localparam int imm_width       = 16;

	typedef enum logic [5:0] {
		op_add  = 6'b000001,
		op_addi = 6'b000010,
		op_subi = 6'b000100,
		op_mov  = 6'b010010,
		op_lw   = 6'b010011,
		op_li   = 6'b010100,
		op_sw   = 6'b010110,
		op_blet = 6'b011010,
		op_j    = 6'b011101,
		op_jal  = 6'b011110,
		op_jr   = 6'b011111,
		op_in   = 6'b100000,
		op_out  = 6'b100001,
		op_halt = 6'b111111
	} opcode_t;

	// r-type layout, i-type reuses rd/shamt as the immediate
	typedef struct packed {
		opcode_t                     opcode;
		logic [reg_addr_width-1:0]   rs;
		logic [reg_addr_width-1:0]   rt;
		logic [reg_addr_width-1:0]   rd;
		logic [10:0]                 shamt_unused;
	} instr_t;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_pass_b,
		alu_le
	} alu_op_t;

	typedef enum logic {
		sel_rt,
		sel_rd
	} write_sel_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_in,
		wb_link
	} wb_src_t;

	typedef struct packed {
		alu_op_t    alu_op;
		logic       use_imm;   // b operand from immediate
		logic       reg_write;
		write_sel_t write_sel;
		wb_src_t    wb_src;
		logic       mem_write;
		logic       branch;
		logic       jump;
		logic       jump_reg;
		logic       link;      // write pc + 1 to r31
		logic       is_in;
		logic       is_out;
		logic       is_halt;
	} ctrl_t;

	typedef struct packed {
		logic                  valid;
		logic [data_width-1:0] data;
	} out_port_t;

endpackage

//--- rtl/instruction_memory.sv
module instruction_memory (
	input  logic [cpu_pkg::pc_width-1:0] pc,
	output cpu_pkg::instr_t              instr
);
	import cpu_pkg::*;

	logic [31:0] word;

	always_comb begin
		case (pc)
			0:  word = 32'b011101_00000000000000000000011011; // to main
			1:  word = 32'b000010_00011_00011_0000000000000110; // open frame
			2:  word = 32'b010010_00111_01011_0000000000000000; // n
			3:  word = 32'b010100_00000_10101_0000000000000000;
			4:  word = 32'b010110_00011_10101_1111111111111111; // fib(i-1)
			5:  word = 32'b010100_00000_10110_0000000000000001;
			6:  word = 32'b010110_00011_10110_0000000000000000; // fib(i)
			7:  word = 32'b010100_00000_10111_0000000000000000;
			8:  word = 32'b010110_00011_10111_1111111111111101; // i = 0
			9:  word = 32'b010011_00011_01100_1111111111111101; // loop head
			10: word = 32'b011010_01100_01011_0000000000011001; // n <= i, done
			11: word = 32'b010100_00000_11000_0000000000000001;
			12: word = 32'b011010_01100_11000_0000000000001111;
			13: word = 32'b010110_00011_01100_1111111111111110;
			14: word = 32'b011101_00000000000000000000010110;
			15: word = 32'b010011_00011_01101_1111111111111111;
			16: word = 32'b010011_00011_01110_0000000000000000;
			17: word = 32'b000001_01101_01110_11001_00000000000; // next term
			18: word = 32'b010110_00011_11001_1111111111111110;
			19: word = 32'b010110_00011_01110_1111111111111111;
			20: word = 32'b010011_00011_01111_1111111111111110;
			21: word = 32'b010110_00011_01111_0000000000000000;
			22: word = 32'b000010_01100_11010_0000000000000001; // i + 1
			23: word = 32'b010110_00011_11010_1111111111111101;
			24: word = 32'b011101_00000000000000000000001001;
			25: word = 32'b010010_01111_00001_0000000000000000; // return value
			26: word = 32'b011111_00000_11111_0000000000000000; // return
			27: word = 32'b000010_00011_00011_0000000000000000; // main
			28: word = 32'b100000_00000_10101_0000000000000000; // read n
			29: word = 32'b010110_00011_10101_0000000000000000;
			30: word = 32'b010011_00011_01011_0000000000000000;
			31: word = 32'b010010_01011_00111_0000000000000000;
			32: word = 32'b011110_00000000000000000000000001; // call fib
			33: word = 32'b010010_00001_10110_0000000000000000;
			34: word = 32'b000100_00011_00011_0000000000000110; // close frame
			35: word = 32'b010010_10110_00111_0000000000000000;
			36: word = 32'b010100_00000_01000_0000000000000010;
			37: word = 32'b100001_00000_00111_0000000000000010; // result out
			38: word = 32'b111111_00000000000000000000000000;
			default: word = '0; // unused tail of the rom
		endcase
	end

	assign instr = instr_t'(word);

	always_comb begin
		if (!$isunknown(pc))
			assert (pc < pc_width'(program_size))
				else $error("instruction_memory: pc %0d beyond program", pc);
	end

endmodule

//--- rtl/instruction_decoder.sv
module instruction_decoder (
	input  logic            clock,
	input  logic            arst_n,
	input  cpu_pkg::instr_t instr,
	output cpu_pkg::ctrl_t  ctrl
);
	import cpu_pkg::*;

	logic opcode_known;

	always_comb begin
		ctrl         = '0;
		opcode_known = 1'b1;
		case (instr.opcode)
			op_add: begin
				ctrl.reg_write = 1'b1;
				ctrl.write_sel = sel_rd;
			end
			op_addi, op_mov: begin // mov carries a zero immediate
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_subi: begin
				ctrl.alu_op    = alu_sub;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_lw: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src    = wb_mem;
			end
			op_li: begin
				ctrl.alu_op    = alu_pass_b;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_sw: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			op_blet: begin
				ctrl.alu_op = alu_le;
				ctrl.branch = 1'b1;
			end
			op_j: ctrl.jump = 1'b1;
			op_jal: begin
				ctrl.jump      = 1'b1;
				ctrl.link      = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src    = wb_link;
			end
			op_jr: ctrl.jump_reg = 1'b1;
			op_in: begin
				ctrl.is_in     = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src    = wb_in;
			end
			op_out: ctrl.is_out = 1'b1;
			op_halt: ctrl.is_halt = 1'b1;
			default: opcode_known = 1'b0; // decodes as a nop
		endcase
	end

	// program only ever fetches defined opcodes
	assert property (@(posedge clock) disable iff (!arst_n) opcode_known)
		else $error("instruction_decoder: unknown opcode %b", instr.opcode);

endmodule

//--- rtl/register_file.sv
module register_file (
	input  logic                          clock,
	input  logic                          arst_n,
	input  logic [4:0]                    ra_addr,
	input  logic [4:0]                    rb_addr,
	output logic [cpu_pkg::data_width-1:0] ra_data,
	output logic [cpu_pkg::data_width-1:0] rb_data,
	input  logic                          we,
	input  logic [4:0]                    wa_addr,
	input  logic [cpu_pkg::data_width-1:0] wd
);
	import cpu_pkg::*;

	localparam int reg_count = 2 ** reg_addr_width;

	logic [data_width-1:0] regs [reg_count];

	// r0 is an ordinary register here
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wa_addr] <= wd;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr]; // also jr target and store data

endmodule

//--- rtl/alu.sv
module alu (
	input  cpu_pkg::alu_op_t              op,
	input  logic [cpu_pkg::data_width-1:0] a,
	input  logic [cpu_pkg::data_width-1:0] b,
	output logic [cpu_pkg::data_width-1:0] result,
	output logic                          le
);
	import cpu_pkg::*;

	logic [data_width-1:0] diff;

	assign diff = a - b;

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = diff;
			alu_pass_b: result = b;
			default:    result = diff; // compare, result unused
		endcase
	end

	// blet takes the branch when rt <= rs
	assign le = $signed(b) <= $signed(a);

endmodule

//--- rtl/data_memory.sv
module data_memory (
	input  logic                                clock,
	input  logic [cpu_pkg::dmem_addr_width-1:0] addr,
	input  logic                                we,
	input  logic [cpu_pkg::data_width-1:0]       wd,
	output logic [cpu_pkg::data_width-1:0]       rd
);
	import cpu_pkg::*;

	logic [data_width-1:0] mem [dmem_words];

	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= wd;
	end

	assign rd = mem[addr]; // async read for lw

	// a write through an unknown sp would scribble the stack
	assert property (@(posedge clock) we |-> !$isunknown(addr))
		else $error("data_memory: write with unknown address");

endmodule

//--- rtl/cpu_core.sv
module cpu_core (
	input  logic                          clock,
	input  logic                          arst_n,
	input  logic [cpu_pkg::data_width-1:0] in_data,
	input  logic                          in_valid,
	output logic                          in_ready,
	output cpu_pkg::out_port_t            out_port,
	output logic                          halted
);
	import cpu_pkg::*;

	logic [pc_width-1:0]        pc;
	logic [pc_width-1:0]        pc_next;
	logic [pc_width-1:0]        pc_plus1;
	instr_t                     instr;
	ctrl_t                      ctrl;
	logic [data_width-1:0]      ra_data;
	logic [data_width-1:0]      rb_data;
	logic [data_width-1:0]      imm;
	logic [data_width-1:0]      alu_b;
	logic [data_width-1:0]      alu_result;
	logic [data_width-1:0]      mem_rd;
	logic [data_width-1:0]      wb_data;
	logic [reg_addr_width-1:0]  wa_addr;
	logic                       le;
	logic                       stall;
	logic                       hold;
	logic                       out_valid;
	logic [data_width-1:0]      out_data;

	instruction_memory imem0 (.pc(pc), .instr(instr));

	instruction_decoder dec0 (.clock(clock), .arst_n(arst_n), .instr(instr), .ctrl(ctrl));

	register_file rf0 (
		.clock(clock), .arst_n(arst_n),
		.ra_addr(instr.rs), .rb_addr(instr.rt),
		.ra_data(ra_data), .rb_data(rb_data),
		.we(ctrl.reg_write && !hold), .wa_addr(wa_addr), .wd(wb_data)
	);

	alu alu0 (.op(ctrl.alu_op), .a(ra_data), .b(alu_b), .result(alu_result), .le(le));

	data_memory dmem0 (
		.clock(clock), .addr(alu_result[dmem_addr_width-1:0]),
		.we(ctrl.mem_write && !halted), .wd(rb_data), .rd(mem_rd)
	);

	assign imm   = {{(data_width - imm_width){instr[imm_width-1]}}, instr[imm_width-1:0]};
	assign alu_b = ctrl.use_imm ? imm : rb_data;

	assign in_ready = ctrl.is_in;
	assign stall    = ctrl.is_in && !in_valid; // wait for a word
	assign hold     = halted || ctrl.is_halt || stall;
	assign pc_plus1 = pc + 1'b1;

	always_comb begin
		if (hold)
			pc_next = pc;
		else if (ctrl.jump_reg)
			pc_next = rb_data[pc_width-1:0];
		else if (ctrl.jump)
			pc_next = instr[pc_width-1:0]; // j/jal target field
		else if (ctrl.branch && le)
			pc_next = imm[pc_width-1:0];
		else
			pc_next = pc_plus1;
	end

	assign wa_addr = ctrl.link ? reg_addr_width'(31) :
		(ctrl.write_sel == sel_rd) ? instr.rd : instr.rt;

	always_comb begin
		case (ctrl.wb_src)
			wb_mem:  wb_data = mem_rd;
			wb_in:   wb_data = in_data;
			wb_link: wb_data = data_width'(pc_plus1); // return address
			default: wb_data = alu_result;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc        <= '0;
			out_valid <= 1'b0;
			halted    <= 1'b0;
		end else begin
			pc        <= pc_next;
			out_valid <= ctrl.is_out && !halted;
			if (ctrl.is_halt)
				halted <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge clock) begin
		if (ctrl.is_out && !halted)
			out_data <= rb_data;
	end

	assign out_port = '{valid: out_valid, data: out_data};

	// one strobe per out, and out is never back to back
	assert property (@(posedge clock) disable iff (!arst_n) out_port.valid |=> !out_port.valid)
		else $error("cpu_core: out strobe held for two cycles");

endmodule

//--- testbench/clock_gen.sv
module clock_gen (
	output logic clock,
	output logic arst_n
);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock; // period 100
	end

	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1; // power-on reset over two edges
	end

endmodule

//--- testbench/tb_top.sv
module tb_top;
	import cpu_pkg::*;

	localparam int run_count  = 8;
	localparam int wait_limit = 5000;

	logic                  clock;
	logic                  por_n;
	logic                  run_rst_n;
	logic                  arst_n;
	logic [data_width-1:0] in_data;
	logic                  in_valid;
	logic                  in_ready;
	out_port_t             out_port;
	logic                  halted;

	logic [data_width-1:0] expected; // fib(n) for the current run
	int                    n_cur;
	int                    out_count;
	logic                  seen_in;

	clock_gen clk0 (.clock(clock), .arst_n(por_n));

	assign arst_n = por_n && run_rst_n; // power-on or per-run reset

	cpu_core dut0 (
		.clock(clock), .arst_n(arst_n),
		.in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
		.out_port(out_port), .halted(halted)
	);

	function automatic logic [data_width-1:0] fib_of(input int n);
		logic [data_width-1:0] prev;
		logic [data_width-1:0] cur;
		logic [data_width-1:0] next;
		prev = '0; // fib(0)
		cur  = 1;  // fib(1)
		for (int k = 1; k < n; k++) begin
			next = prev + cur;
			prev = cur;
			cur  = next;
		end
		return cur;
	endfunction

	task automatic report_failure(input string msg);
		$display("** Error at time %0t: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timed out after %0d cycles waiting for %s", wait_limit, what);
		$display("Errors found");
		$fatal(1, "stopped on timeout");
	endtask

	// per-run bookkeeping, cleared by every reset
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			out_count <= 0;
			seen_in   <= 1'b0;
		end else begin
			if (out_port.valid)
				out_count <= out_count + 1;
			if (in_ready)
				seen_in <= 1'b1;
		end
	end

	a_reset_quiet: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(arst_n) |-> !in_ready && !out_port.valid && !halted)
		else report_failure("outputs not idle after reset");

	a_quiet_before_in: assert property (@(posedge clock) disable iff (!arst_n)
		!seen_in |-> !out_port.valid && !halted)
		else report_failure("output or halt before the program read its input");

	a_ready_holds: assert property (@(posedge clock) disable iff (!arst_n)
		in_ready && !in_valid |=> in_ready)
		else report_failure("in_ready dropped without a handshake");

	a_ready_falls: assert property (@(posedge clock) disable iff (!arst_n)
		in_ready && in_valid |=> !in_ready)
		else report_failure("in_ready still high after the handshake");

	a_out_value: assert property (@(posedge clock) disable iff (!arst_n)
		out_port.valid |-> out_port.data == expected)
		else report_failure($sformatf("out data %0d, expected %0d for n = %0d",
			out_port.data, expected, n_cur));

	a_single_out: assert property (@(posedge clock) disable iff (!arst_n)
		out_port.valid |-> out_count == 0)
		else report_failure("second out strobe in one run");

	a_halt_follows_out: assert property (@(posedge clock) disable iff (!arst_n)
		out_port.valid |=> halted && !out_port.valid)
		else report_failure("halted not set on the cycle after the out strobe");

	a_halt_has_cause: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(halted) |-> $past(out_port.valid))
		else report_failure("halted rose without a preceding out strobe");

	a_halt_sticky: assert property (@(posedge clock) disable iff (!arst_n)
		halted |=> halted && !out_port.valid && !in_ready)
		else report_failure("activity after halt");

	task automatic apply_reset();
		@(negedge clock);
		run_rst_n = 1'b0;
		in_valid  = 1'b0;
		repeat (2) @(negedge clock);
		run_rst_n = 1'b1;
	endtask

	task automatic wait_for_ready();
		int cycles;
		cycles = 0;
		while (!in_ready && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (!in_ready)
			stop_on_timeout("in_ready");
	endtask

	task automatic send_input(input int n, input int delay);
		repeat (delay) @(negedge clock); // stall the in instruction
		in_data  = n;
		in_valid = 1'b1;
		@(negedge clock);
		in_valid = 1'b0;
		in_data  = $urandom; // junk once the word is taken
	endtask

	task automatic wait_for_halt();
		int cycles;
		cycles = 0;
		while (!halted && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (!halted)
			stop_on_timeout("halted");
	endtask

	task automatic one_run(input bit abort);
		int n;
		int delay;
		n     = $urandom_range(24, 2);
		delay = $urandom_range(3, 0);
		apply_reset();
		n_cur    = n;
		expected = fib_of(n);
		wait_for_ready();
		send_input(n, delay);
		if (abort) begin
			repeat (5 + $urandom_range(10, 0)) @(negedge clock); // reset lands mid-loop
		end else begin
			wait_for_halt();
			assert (out_count == 1)
				else report_failure($sformatf("%0d out strobes before halt", out_count));
			repeat (20) @(negedge clock); // must stay frozen
		end
	endtask

	initial begin
		int cycles;
		void'($urandom(32'h38ae_551b));
		run_rst_n = 1'b1;
		in_valid  = 1'b0;
		in_data   = '0;
		expected  = '0;
		n_cur     = 0;
		cycles    = 0;
		while (por_n !== 1'b1 && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (por_n !== 1'b1)
			stop_on_timeout("power-on reset release");
		for (int r = 0; r < run_count; r++)
			one_run(r == 2 || r == 5);
		$display("No errors");
		$finish;
	end

endmodule

//--- tb.f
rtl/cpu_pkg.sv
rtl/instruction_memory.sv
rtl/instruction_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/data_memory.sv
rtl/cpu_core.sv
testbench/clock_gen.sv
testbench/tb_top.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_top
RTL_TOP  := cpu_core
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then echo "simulation did not finish"; exit 1; \
	else echo "simulation passed"; fi

lint:
	$(SIM) --lint-only -Wall --top-module $(RTL_TOP) $(filter rtl/%,$(SOURCES))

clean:
	rm -rf $(BUILD) $(LOG)
